//--- design/dem_uart_pkg.sv
package dem_uart_pkg;

   // One host character
   typedef logic [7:0] char_t;

   // One flit on the debug network, also one packed payload word
   typedef logic [15:0] word_t;

   // Payload word count of one burst
   typedef logic [4:0] burst_len_t;

   // Packet type code in bits 15:14 of the flags flit
   localparam logic [1:0] FLIT_TYPE_EVENT = 2'b10;

   // Set when the last payload word holds only its low byte
   localparam int FLAG_ODD_BIT = 10;

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_DEST,
      TX_SRC,
      TX_FLAGS,
      TX_PAYLOAD
   } tx_state_e;

   typedef enum logic [1:0] {
      RX_DEST,
      RX_SRC,
      RX_FLAGS,
      RX_PAYLOAD
   } rx_state_e;

endpackage

//--- design/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
   parameter int WIDTH = 16,
   parameter int DEPTH = 16
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [WIDTH-1:0] wr_data,
   input  logic             wr_en,
   output logic             full,
   output logic [WIDTH-1:0] rd_data,
   input  logic             rd_en,
   output logic             empty
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   logic [WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic [AW:0]      count;
   logic             do_wr;
   logic             do_rd;

   assign full  = (count == (AW + 1)'(DEPTH));
   assign empty = (count == '0);
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   // Head entry is visible without a read
   assign rd_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (do_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

//--- design/char_packer.sv
`timescale 1ns/1ps

module char_packer #(
   parameter int MAX_PAYLOAD_WORDS = 8,
   parameter int FLUSH_TIMEOUT     = 20
) (
   input  logic                     clk,
   input  logic                     rst,
   input  dem_uart_pkg::char_t      tx_char,
   input  logic                     tx_valid,
   output logic                     tx_ready,
   output dem_uart_pkg::word_t      word_data,
   output logic                     word_half,
   output logic                     word_wr,
   input  logic                     word_full,
   output dem_uart_pkg::burst_len_t desc_len,
   output logic                     desc_odd,
   output logic                     desc_wr,
   input  logic                     desc_full
);
   import dem_uart_pkg::*;

   localparam int TW = $clog2(FLUSH_TIMEOUT + 1);

   char_t      buf_lo;
   char_t      buf_hi;
   logic [1:0] buf_cnt;
   burst_len_t word_cnt;
   logic [TW-1:0] idle_cnt;
   logic       accept;
   logic       pack;
   logic       flush;
   logic       timer_done;
   logic       burst_full;

   assign tx_ready   = !word_full && !desc_full;
   assign accept     = tx_valid && tx_ready;
   // A character arriving at a full buffer pushes the held pair out
   assign pack       = accept && (buf_cnt == 2'd2);
   assign timer_done = (idle_cnt == TW'(FLUSH_TIMEOUT - 1));
   assign flush      = timer_done && (buf_cnt != 2'd0) && tx_ready && !tx_valid;
   assign burst_full = (word_cnt == burst_len_t'(MAX_PAYLOAD_WORDS - 1));

   // High byte stays zero when only one character is held
   assign word_data = {((buf_cnt == 2'd2) ? buf_hi : 8'h00), buf_lo};
   assign word_half = (buf_cnt == 2'd1);
   assign word_wr   = pack || flush;

   // Descriptor goes out together with the closing word
   assign desc_len = word_cnt + 1'b1;
   assign desc_odd = word_half;
   assign desc_wr  = flush || (pack && burst_full);

   always_ff @(posedge clk) begin
      if (accept) begin
         if (buf_cnt == 2'd1) begin
            buf_hi <= tx_char;
         end else begin
            buf_lo <= tx_char;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         buf_cnt  <= '0;
         word_cnt <= '0;
         idle_cnt <= '0;
      end else begin
         if (accept) begin
            idle_cnt <= '0;
            buf_cnt  <= pack ? 2'd1 : buf_cnt + 2'd1;
         end else if (flush) begin
            idle_cnt <= '0;
            buf_cnt  <= '0;
         end else if ((buf_cnt != 2'd0) && !timer_done) begin
            idle_cnt <= idle_cnt + 1'b1;
         end

         if (desc_wr) begin
            word_cnt <= '0;
         end else if (pack) begin
            word_cnt <= word_cnt + 1'b1;
         end
      end
   end

endmodule

//--- design/event_packetizer.sv
`timescale 1ns/1ps

module event_packetizer (
   input  logic                     clk,
   input  logic                     rst,
   input  dem_uart_pkg::word_t      id,
   input  dem_uart_pkg::word_t      event_dest,
   input  dem_uart_pkg::burst_len_t desc_len,
   input  logic                     desc_odd,
   input  logic                     desc_empty,
   output logic                     desc_rd,
   input  dem_uart_pkg::word_t      word_data,
   input  logic                     word_empty,
   output logic                     word_rd,
   output dem_uart_pkg::word_t      debug_out_data,
   output logic                     debug_out_valid,
   output logic                     debug_out_last,
   input  logic                     debug_out_ready
);
   import dem_uart_pkg::*;

   tx_state_e  state;
   burst_len_t remaining;
   logic       odd_q;
   word_t      flags_flit;
   logic       out_xfer;

   always_comb begin
      flags_flit = '0;
      flags_flit[15:14] = FLIT_TYPE_EVENT;
      flags_flit[FLAG_ODD_BIT] = odd_q;
   end

   assign desc_rd  = (state == TX_IDLE) && !desc_empty;
   assign out_xfer = debug_out_valid && debug_out_ready;
   assign word_rd  = (state == TX_PAYLOAD) && out_xfer;

   always_comb begin
      debug_out_data  = '0;
      debug_out_valid = 1'b0;
      debug_out_last  = 1'b0;
      case (state)
         TX_DEST: begin
            debug_out_data  = event_dest;
            debug_out_valid = 1'b1;
         end
         TX_SRC: begin
            debug_out_data  = id;
            debug_out_valid = 1'b1;
         end
         TX_FLAGS: begin
            debug_out_data  = flags_flit;
            debug_out_valid = 1'b1;
         end
         TX_PAYLOAD: begin
            // Stall here until the next word is buffered
            debug_out_data  = word_data;
            debug_out_valid = !word_empty;
            debug_out_last  = (remaining == burst_len_t'(1));
         end
         default: begin
            debug_out_valid = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (desc_rd) begin
         odd_q <= desc_odd;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= TX_IDLE;
         remaining <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               if (desc_rd) begin
                  remaining <= desc_len;
                  state     <= TX_DEST;
               end
            end
            TX_DEST: begin
               if (out_xfer) state <= TX_SRC;
            end
            TX_SRC: begin
               if (out_xfer) state <= TX_FLAGS;
            end
            TX_FLAGS: begin
               if (out_xfer) state <= TX_PAYLOAD;
            end
            TX_PAYLOAD: begin
               if (out_xfer) begin
                  remaining <= remaining - 1'b1;
                  if (debug_out_last) begin
                     state <= TX_IDLE;
                  end
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

endmodule

//--- design/packet_parser.sv
`timescale 1ns/1ps

module packet_parser (
   input  logic                clk,
   input  logic                rst,
   input  dem_uart_pkg::word_t debug_in_data,
   input  logic                debug_in_valid,
   input  logic                debug_in_last,
   output logic                debug_in_ready,
   output dem_uart_pkg::word_t word_data,
   output logic                word_half,
   output logic                word_wr,
   input  logic                word_full
);
   import dem_uart_pkg::*;

   rx_state_e state;
   logic      odd_q;
   logic      in_xfer;

   // Header flits are always taken, payload waits for buffer room
   assign debug_in_ready = (state == RX_PAYLOAD) ? !word_full : 1'b1;
   assign in_xfer        = debug_in_valid && debug_in_ready;

   assign word_data = debug_in_data;
   assign word_half = debug_in_last && odd_q;
   assign word_wr   = (state == RX_PAYLOAD) && in_xfer;

   always_ff @(posedge clk) begin
      if ((state == RX_FLAGS) && in_xfer) begin
         odd_q <= debug_in_data[FLAG_ODD_BIT];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= RX_DEST;
      end else if (in_xfer) begin
         case (state)
            RX_DEST: begin
               state <= debug_in_last ? RX_DEST : RX_SRC;
            end
            RX_SRC: begin
               state <= debug_in_last ? RX_DEST : RX_FLAGS;
            end
            RX_FLAGS: begin
               // A packet that ends in its header carries no payload
               state <= debug_in_last ? RX_DEST : RX_PAYLOAD;
            end
            RX_PAYLOAD: begin
               if (debug_in_last) begin
                  state <= RX_DEST;
               end
            end
            default: state <= RX_DEST;
         endcase
      end
   end

endmodule

//--- design/char_unpacker.sv
`timescale 1ns/1ps

module char_unpacker (
   input  logic                clk,
   input  logic                rst,
   input  dem_uart_pkg::word_t word_data,
   input  logic                word_half,
   input  logic                word_empty,
   output logic                word_rd,
   output dem_uart_pkg::char_t rx_char,
   output logic                rx_valid,
   input  logic                rx_ready
);

   // Selects the high byte once the low byte has gone out
   logic high_sel;
   logic char_xfer;
   logic last_char;

   assign rx_valid  = !word_empty;
   assign rx_char   = high_sel ? word_data[15:8] : word_data[7:0];
   assign char_xfer = rx_valid && rx_ready;

   // Half words end after their low byte
   assign last_char = high_sel || word_half;
   assign word_rd   = char_xfer && last_char;

   always_ff @(posedge clk) begin
      if (rst) begin
         high_sel <= 1'b0;
      end else if (char_xfer) begin
         high_sel <= !last_char;
      end
   end

endmodule

//--- design/dem_uart.sv
`timescale 1ns/1ps

module dem_uart #(
   parameter int FIFO_DEPTH        = 16,
   parameter int MAX_PAYLOAD_WORDS = 8,
   parameter int FLUSH_TIMEOUT     = 20
) (
   input  logic                clk,
   input  logic                rst,
   input  dem_uart_pkg::word_t id,
   input  dem_uart_pkg::word_t event_dest,
   input  dem_uart_pkg::char_t tx_char,
   input  logic                tx_valid,
   output logic                tx_ready,
   output dem_uart_pkg::char_t rx_char,
   output logic                rx_valid,
   input  logic                rx_ready,
   output dem_uart_pkg::word_t debug_out_data,
   output logic                debug_out_valid,
   output logic                debug_out_last,
   input  logic                debug_out_ready,
   input  dem_uart_pkg::word_t debug_in_data,
   input  logic                debug_in_valid,
   input  logic                debug_in_last,
   output logic                debug_in_ready
);
   import dem_uart_pkg::*;

   // Transmit side
   word_t      tx_word_data;
   logic       tx_word_half;
   logic       tx_word_wr;
   logic       tx_word_full;
   logic [16:0] tx_word_q;
   logic       tx_word_rd;
   logic       tx_word_empty;
   burst_len_t tx_desc_len;
   logic       tx_desc_odd;
   logic       tx_desc_wr;
   logic       tx_desc_full;
   logic [5:0] tx_desc_q;
   logic       tx_desc_rd;
   logic       tx_desc_empty;

   // Receive side
   word_t      rx_word_data;
   logic       rx_word_half;
   logic       rx_word_wr;
   logic       rx_word_full;
   logic [16:0] rx_word_q;
   logic       rx_word_rd;
   logic       rx_word_empty;

   char_packer #(
      .MAX_PAYLOAD_WORDS (MAX_PAYLOAD_WORDS),
      .FLUSH_TIMEOUT     (FLUSH_TIMEOUT)
   ) u_char_packer (
      .clk       (clk),
      .rst       (rst),
      .tx_char   (tx_char),
      .tx_valid  (tx_valid),
      .tx_ready  (tx_ready),
      .word_data (tx_word_data),
      .word_half (tx_word_half),
      .word_wr   (tx_word_wr),
      .word_full (tx_word_full),
      .desc_len  (tx_desc_len),
      .desc_odd  (tx_desc_odd),
      .desc_wr   (tx_desc_wr),
      .desc_full (tx_desc_full)
   );

   // Half tag rides in bit 16
   sync_fifo #(.WIDTH(17), .DEPTH(FIFO_DEPTH)) tx_word_fifo (
      .clk     (clk),
      .rst     (rst),
      .wr_data ({tx_word_half, tx_word_data}),
      .wr_en   (tx_word_wr),
      .full    (tx_word_full),
      .rd_data (tx_word_q),
      .rd_en   (tx_word_rd),
      .empty   (tx_word_empty)
   );

   // Odd flag above the word count
   sync_fifo #(.WIDTH(6), .DEPTH(FIFO_DEPTH)) tx_desc_fifo (
      .clk     (clk),
      .rst     (rst),
      .wr_data ({tx_desc_odd, tx_desc_len}),
      .wr_en   (tx_desc_wr),
      .full    (tx_desc_full),
      .rd_data (tx_desc_q),
      .rd_en   (tx_desc_rd),
      .empty   (tx_desc_empty)
   );

   event_packetizer u_event_packetizer (
      .clk             (clk),
      .rst             (rst),
      .id              (id),
      .event_dest      (event_dest),
      .desc_len        (tx_desc_q[4:0]),
      .desc_odd        (tx_desc_q[5]),
      .desc_empty      (tx_desc_empty),
      .desc_rd         (tx_desc_rd),
      .word_data       (tx_word_q[15:0]),
      .word_empty      (tx_word_empty),
      .word_rd         (tx_word_rd),
      .debug_out_data  (debug_out_data),
      .debug_out_valid (debug_out_valid),
      .debug_out_last  (debug_out_last),
      .debug_out_ready (debug_out_ready)
   );

   packet_parser u_packet_parser (
      .clk            (clk),
      .rst            (rst),
      .debug_in_data  (debug_in_data),
      .debug_in_valid (debug_in_valid),
      .debug_in_last  (debug_in_last),
      .debug_in_ready (debug_in_ready),
      .word_data      (rx_word_data),
      .word_half      (rx_word_half),
      .word_wr        (rx_word_wr),
      .word_full      (rx_word_full)
   );

   sync_fifo #(.WIDTH(17), .DEPTH(FIFO_DEPTH)) rx_word_fifo (
      .clk     (clk),
      .rst     (rst),
      .wr_data ({rx_word_half, rx_word_data}),
      .wr_en   (rx_word_wr),
      .full    (rx_word_full),
      .rd_data (rx_word_q),
      .rd_en   (rx_word_rd),
      .empty   (rx_word_empty)
   );

   char_unpacker u_char_unpacker (
      .clk        (clk),
      .rst        (rst),
      .word_data  (rx_word_q[15:0]),
      .word_half  (rx_word_q[16]),
      .word_empty (rx_word_empty),
      .word_rd    (rx_word_rd),
      .rx_char    (rx_char),
      .rx_valid   (rx_valid),
      .rx_ready   (rx_ready)
   );

endmodule

//--- dv/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
   parameter real PERIOD_NS = 8.0
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   // Toggles every half period
   always begin
      #(PERIOD_NS / 2.0);
      clk = ~clk;
   end

endmodule

//--- dv/dem_uart_tb.sv
`timescale 1ns/1ps

module dem_uart_tb;

   localparam int FIFO_DEPTH        = 16;
   localparam int MAX_PAYLOAD_WORDS = 8;
   localparam int FLUSH_TIMEOUT     = 20;
   localparam int RESET_CYCLES      = 2;

   localparam logic [15:0] EVENT_DEST       = 16'h0042;
   localparam logic [15:0] SRC_ID           = 16'ha5c3;
   localparam logic [15:0] TYPE_EVENT_FLAGS = 16'h8000;
   localparam logic [15:0] ODD_FLAG_MASK    = 16'h0400;

   // Stimulus table with direction (0 tx, 1 rx), characters, first character,
   // odd flag of an rx packet and random back-pressure
   localparam int NUM_ROWS = 4;
   localparam int ROW_DIR   [NUM_ROWS] = '{0, 0, 1, 1};
   localparam int ROW_CHARS [NUM_ROWS] = '{3, 32, 5, 8};
   localparam int ROW_FIRST [NUM_ROWS] = '{8'h41, 8'h61, 8'h30, 8'h50};
   localparam int ROW_ODD   [NUM_ROWS] = '{0, 0, 1, 0};
   localparam int ROW_BP    [NUM_ROWS] = '{0, 1, 0, 1};

   logic        clk;
   logic        rst;
   logic [15:0] id;
   logic [15:0] event_dest;
   logic [7:0]  tx_char;
   logic        tx_valid;
   logic        tx_ready;
   logic [7:0]  rx_char;
   logic        rx_valid;
   logic        rx_ready = 1'b1;
   logic [15:0] debug_out_data;
   logic        debug_out_valid;
   logic        debug_out_last;
   logic        debug_out_ready = 1'b1;
   logic [15:0] debug_in_data;
   logic        debug_in_valid;
   logic        debug_in_last;
   logic        debug_in_ready;

   integer      seed = 60059;
   logic [31:0] rnd_bits;
   logic        bp_active = 1'b0;
   int          error_count = 0;
   int          row_errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   // Bit 16 carries last, bits 15:0 the flit
   logic [16:0] exp_flits [$];
   logic [16:0] in_flits [$];
   logic [7:0]  exp_chars [$];

   clk_gen #(.PERIOD_NS(8.0)) u_clk_gen (.clk(clk));

   dem_uart #(
      .FIFO_DEPTH        (FIFO_DEPTH),
      .MAX_PAYLOAD_WORDS (MAX_PAYLOAD_WORDS),
      .FLUSH_TIMEOUT     (FLUSH_TIMEOUT)
   ) u_dem_uart (
      .clk             (clk),
      .rst             (rst),
      .id              (id),
      .event_dest      (event_dest),
      .tx_char         (tx_char),
      .tx_valid        (tx_valid),
      .tx_ready        (tx_ready),
      .rx_char         (rx_char),
      .rx_valid        (rx_valid),
      .rx_ready        (rx_ready),
      .debug_out_data  (debug_out_data),
      .debug_out_valid (debug_out_valid),
      .debug_out_last  (debug_out_last),
      .debug_out_ready (debug_out_ready),
      .debug_in_data   (debug_in_data),
      .debug_in_valid  (debug_in_valid),
      .debug_in_last   (debug_in_last),
      .debug_in_ready  (debug_in_ready)
   );

   // Sink readiness goes random while a row asks for back-pressure
   always @(posedge clk) begin
      rnd_bits = $random(seed);
      if (bp_active) begin
         debug_out_ready <= rnd_bits[0];
         rx_ready        <= rnd_bits[1];
      end else begin
         debug_out_ready <= 1'b1;
         rx_ready        <= 1'b1;
      end
   end

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      if (got !== exp) begin
         $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
         error_count++;
         row_errors++;
      end
   endtask

   // Character idx of a row in the low byte, the next one above it
   function automatic logic [15:0] pair_word(input int n, input logic [7:0] first,
                                             input int idx);
      logic [7:0] lo;
      logic [7:0] hi;
      lo = first + 8'(2 * idx);
      hi = (2 * idx + 1 < n) ? first + 8'(2 * idx + 1) : 8'h00;
      return {hi, lo};
   endfunction

   function automatic void build_tx_expect(input int n, input logic [7:0] first);
      int          nwords;
      int          w;
      int          len;
      logic        odd;
      logic [15:0] flags;
      nwords = (n + 1) / 2;
      exp_flits.delete();
      w = 0;
      // Bursts close at the word limit, the rest goes out on the idle flush
      while (w < nwords) begin
         len   = (nwords - w > MAX_PAYLOAD_WORDS) ? MAX_PAYLOAD_WORDS : nwords - w;
         odd   = (n % 2 == 1) && (w + len == nwords);
         flags = TYPE_EVENT_FLAGS | (odd ? ODD_FLAG_MASK : 16'h0000);
         exp_flits.push_back({1'b0, EVENT_DEST});
         exp_flits.push_back({1'b0, SRC_ID});
         exp_flits.push_back({1'b0, flags});
         for (int i = 0; i < len; i++) begin
            exp_flits.push_back({(i == len - 1), pair_word(n, first, w + i)});
         end
         w += len;
      end
   endfunction

   function automatic void build_rx_packet(input int n, input logic [7:0] first,
                                           input logic odd);
      int nwords;
      nwords = (n + 1) / 2;
      in_flits.delete();
      exp_chars.delete();
      in_flits.push_back({1'b0, 16'h0007});
      in_flits.push_back({1'b0, 16'h0003});
      in_flits.push_back({1'b0, TYPE_EVENT_FLAGS | (odd ? ODD_FLAG_MASK : 16'h0000)});
      for (int i = 0; i < nwords; i++) begin
         in_flits.push_back({(i == nwords - 1), pair_word(n, first, i)});
      end
      for (int i = 0; i < n; i++) begin
         exp_chars.push_back(first + 8'(i));
      end
   endfunction

   task automatic drive_tx_chars(input int n, input logic [7:0] first);
      for (int i = 0; i < n; i++) begin
         @(posedge clk);
         tx_valid <= 1'b1;
         tx_char  <= first + 8'(i);
         do begin
            @(negedge clk);
         end while (!tx_ready);
      end
      @(posedge clk);
      tx_valid <= 1'b0;
   endtask

   task automatic collect_out_flits();
      logic [16:0] exp;
      while (exp_flits.size() > 0) begin
         @(negedge clk);
         if (debug_out_valid && debug_out_ready) begin
            exp = exp_flits.pop_front();
            check_value("debug_out_data", debug_out_data, exp[15:0]);
            check_value("debug_out_last", 16'(debug_out_last), 16'(exp[16]));
         end
      end
   endtask

   task automatic drive_in_flits();
      logic [16:0] flit;
      while (in_flits.size() > 0) begin
         flit = in_flits.pop_front();
         @(posedge clk);
         debug_in_valid <= 1'b1;
         debug_in_data  <= flit[15:0];
         debug_in_last  <= flit[16];
         do begin
            @(negedge clk);
         end while (!debug_in_ready);
      end
      @(posedge clk);
      debug_in_valid <= 1'b0;
      debug_in_last  <= 1'b0;
   endtask

   task automatic collect_rx_chars();
      logic [7:0] exp;
      while (exp_chars.size() > 0) begin
         @(negedge clk);
         if (rx_valid && rx_ready) begin
            exp = exp_chars.pop_front();
            check_value("rx_char", 16'(rx_char), 16'(exp));
         end
      end
   endtask

   // Limit grows with the table
   initial begin
      int limit;
      limit = RESET_CYCLES;
      for (int r = 0; r < NUM_ROWS; r++) begin
         limit += 200 + 20 * ROW_CHARS[r];
      end
      repeat (limit) @(posedge clk);
      $display("Timeout: the tests did not complete within %0d cycles", limit);
      $display("Finished with errors");
      $finish;
   end

   initial begin
      rst            = 1'b1;
      id             = SRC_ID;
      event_dest     = EVENT_DEST;
      tx_char        = 8'h00;
      tx_valid       = 1'b0;
      debug_in_data  = 16'h0000;
      debug_in_valid = 1'b0;
      debug_in_last  = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;

      @(negedge clk);
      check_value("debug_out_valid", 16'(debug_out_valid), 16'd0);
      check_value("rx_valid", 16'(rx_valid), 16'd0);
      check_value("tx_ready", 16'(tx_ready), 16'd1);
      check_value("debug_in_ready", 16'(debug_in_ready), 16'd1);
      tests_run++;
      if (row_errors != 0) tests_failed++;
      $display("Reset values: %0d mismatches", row_errors);

      for (int r = 0; r < NUM_ROWS; r++) begin
         row_errors = 0;
         @(negedge clk);
         bp_active = (ROW_BP[r] != 0);
         if (ROW_DIR[r] == 0) begin
            build_tx_expect(ROW_CHARS[r], 8'(ROW_FIRST[r]));
            fork
               drive_tx_chars(ROW_CHARS[r], 8'(ROW_FIRST[r]));
               collect_out_flits();
            join
         end else begin
            build_rx_packet(ROW_CHARS[r], 8'(ROW_FIRST[r]), ROW_ODD[r] != 0);
            fork
               drive_in_flits();
               collect_rx_chars();
            join
         end
         bp_active = 1'b0;
         // Nothing may follow the expected traffic
         repeat (4) @(negedge clk);
         if (ROW_DIR[r] == 0) begin
            check_value("debug_out_valid", 16'(debug_out_valid), 16'd0);
         end else begin
            check_value("rx_valid", 16'(rx_valid), 16'd0);
         end
         tests_run++;
         if (row_errors != 0) tests_failed++;
         if (ROW_DIR[r] == 0) begin
            $display("Row %0d tx %0d chars: %0d mismatches", r, ROW_CHARS[r], row_errors);
         end else begin
            $display("Row %0d rx %0d chars: %0d mismatches", r, ROW_CHARS[r], row_errors);
         end
      end

      $display("Tests run %0d, failed %0d, mismatches %0d",
               tests_run, tests_failed, error_count);
      if (error_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- flist.f
design/dem_uart_pkg.sv
design/sync_fifo.sv
design/char_packer.sv
design/event_packetizer.sv
design/packet_parser.sv
design/char_unpacker.sv
design/dem_uart.sv
dv/clk_gen.sv
dv/dem_uart_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dem_uart_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx 'Finished with no errors'

clean:
	rm -rf $(OBJ_DIR)
